// ==== include/prof_params.svh ====
// Sizes for the profiler; NUM_FUNCS must equal NUM_BANKS times a power of two slots per bank
`ifndef PROF_PARAMS_SVH
`define PROF_PARAMS_SVH

// Function numbering, last number is the catch-all for unknown targets
`define PROF_NUM_FUNCS    16
`define PROF_FUNC_BITS    4
`define PROF_UNKNOWN_FUNC 15

// Counter banks, bank is taken from the low function bits
`define PROF_NUM_BANKS    4
`define PROF_BANK_BITS    $clog2(`PROF_NUM_BANKS)
`define PROF_SLOT_BITS    (`PROF_FUNC_BITS - `PROF_BANK_BITS)

`define PROF_STACK_DEPTH  8
`define PROF_COUNT_WIDTH  32
`define PROF_ADDR_BITS    8
`endif

// ==== hw/prof_event_pkg.sv ====
// Trace event encodings; increment options are one-hot and only one bit is expected set
package prof_event_pkg;
	// Increment option, one bit per counted event
	typedef logic [4:0] inc_sel_t;
	localparam inc_sel_t INC_INSTR  = 5'b00001;
	localparam inc_sel_t INC_CYCLE  = 5'b00010;
	localparam inc_sel_t INC_STALL  = 5'b00100;
	localparam inc_sel_t INC_ISTALL = 5'b01000;
	localparam inc_sel_t INC_DSTALL = 5'b10000;

	// Decoded operation handed down the pipeline
	typedef enum logic [1:0] {
		OP_NONE = 2'd0,
		OP_CALL = 2'd1,
		OP_RETN = 2'd2
	} trace_op_t;

	// MIPS fields used by the call/return decode
	localparam logic [5:0] OPC_SPECIAL = 6'd0;
	localparam logic [5:0] OPC_JAL     = 6'd3;
	localparam logic [5:0] FUNCT_JR    = 6'd8;
	localparam logic [5:0] FUNCT_JALR  = 6'd9;
	localparam logic [4:0] REG_RA      = 5'd31;
endpackage

// ==== hw/prof_map_pkg.sv ====
// Bus map; bit 7 selects config, bits 7:6 both low select the table, reads always hit counters
package prof_map_pkg;
	// Write region decoded from the two top address bits
	typedef enum logic [1:0] {
		REG_TABLE   = 2'd0,
		REG_CONFIG  = 2'd1,
		// Read-only space, writes landing here are dropped
		REG_COUNTER = 2'd2
	} map_region_t;

	// Config register select from the low address bits
	typedef enum logic [1:0] {
		CFG_INC_MASK = 2'd0,
		CFG_DO_HIER  = 2'd1,
		CFG_INIT_PC  = 2'd2
	} cfg_sel_t;
endpackage

// ==== hw/prof_config_regs.sv ====
// Writes act on the edge with mm_wren high; init_pc resets to all ones so nothing starts by accident
`timescale 1ns/1ps
`include "prof_params.svh"

module prof_config_regs import prof_event_pkg::*, prof_map_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`PROF_ADDR_BITS-1:0] mm_addr,
	input  logic                       mm_wren,
	input  logic [31:0]                mm_wrdata,
	output inc_sel_t                   inc_mask,
	output logic                       do_hier,
	output logic [31:0]                init_pc,
	output logic                       tbl_wren
);
	map_region_t region;
	cfg_sel_t    cfg_sel;

	// Region from the two top address bits
	always_comb begin
		if (mm_addr[`PROF_ADDR_BITS-1])
			region = REG_CONFIG;
		else if (!mm_addr[`PROF_ADDR_BITS-2])
			region = REG_TABLE;
		else
			region = REG_COUNTER;
	end

	assign cfg_sel = cfg_sel_t'(mm_addr[1:0]);

	// Table writes go straight to the lookup on the same edge
	assign tbl_wren = mm_wren && (region == REG_TABLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			inc_mask <= '0;
			do_hier  <= 1'b0;
			init_pc  <= '1;
		end else if (mm_wren && (region == REG_CONFIG)) begin
			case (cfg_sel)
				CFG_INC_MASK: inc_mask <= mm_wrdata[$bits(inc_sel_t)-1:0];
				CFG_DO_HIER:  do_hier  <= mm_wrdata[0];
				CFG_INIT_PC:  init_pc  <= mm_wrdata;
				default: ;
			endcase
		end
	end
endmodule

// ==== hw/prof_trace_front.sv ====
// Every ins_valid cycle is one retired instruction; jalr target is the pc of the next valid one
`timescale 1ns/1ps

module prof_trace_front import prof_event_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic [31:0] pc_in,
	input  logic [31:0] instr_in,
	input  logic      ins_valid,
	input  logic      istall,
	input  logic      dstall,
	input  inc_sel_t  inc_mask,
	input  logic [31:0] init_pc,
	output logic [31:0] ev_pc,
	output trace_op_t ev_op,
	output logic      ev_inc
);
	logic        started;
	logic        jalr_pend;
	logic [31:0] pc_prev;
	logic        pc_chg;
	logic        inc_now;
	logic        is_jal;
	logic        is_jalr;
	logic        is_ret;
	logic [31:0] jal_target;
	logic [31:0] call_pc;

	// Instruction fields
	assign is_jal = ins_valid && (instr_in[31:26] == OPC_JAL);
	assign is_jalr = ins_valid && (instr_in[31:26] == OPC_SPECIAL) && (instr_in[5:0] == FUNCT_JALR);
	assign is_ret = ins_valid && (instr_in[31:26] == OPC_SPECIAL) && (instr_in[5:0] == FUNCT_JR)
		&& (instr_in[25:21] == REG_RA);
	assign jal_target = {pc_in[31:28], instr_in[25:0], 2'b00};

	// Instruction count only moves when the pc does
	assign pc_chg = ins_valid && (pc_in != pc_prev);
	assign inc_now = (|(inc_mask & INC_INSTR) && pc_chg)
		|| |(inc_mask & INC_CYCLE)
		|| (|(inc_mask & INC_STALL) && (istall || dstall))
		|| (|(inc_mask & INC_ISTALL) && istall)
		|| (|(inc_mask & INC_DSTALL) && dstall);

	// Jal carries its own target, a pending jalr and the start call use the current pc
	assign call_pc = (started && is_jal && !jalr_pend) ? jal_target : pc_in;

	always_ff @(posedge clk) begin
		if (reset) begin
			started   <= 1'b0;
			jalr_pend <= 1'b0;
			pc_prev   <= '0;
			ev_op     <= OP_NONE;
			ev_inc    <= 1'b0;
		end else begin
			pc_prev <= pc_in;
			ev_op   <= OP_NONE;
			ev_inc  <= 1'b0;
			if (!started) begin
				// Start cycle pretends a call into init_pc
				if (pc_in == init_pc) begin
					started <= 1'b1;
					ev_op   <= OP_CALL;
					ev_inc  <= inc_now;
				end
			end else begin
				ev_inc <= inc_now;
				if (ins_valid && jalr_pend) begin
					jalr_pend <= 1'b0;
					ev_op     <= OP_CALL;
				end else if (is_jal)
					ev_op <= OP_CALL;
				else if (is_jalr)
					jalr_pend <= 1'b1;
				else if (is_ret)
					ev_op <= OP_RETN;
			end
		end
	end

	always_ff @(posedge clk) begin
		ev_pc <= call_pc;
	end
endmodule

// ==== hw/prof_func_lookup.sv ====
// Direct compare over table slots 0 to 14; writes to slot 15 are ignored and lowest match wins
`timescale 1ns/1ps
`include "prof_params.svh"

module prof_func_lookup import prof_event_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [31:0]                ev_pc,
	input  trace_op_t                  ev_op,
	input  logic                       ev_inc,
	input  logic                       tbl_wren,
	input  logic [`PROF_ADDR_BITS-1:0] mm_addr,
	input  logic [31:0]                mm_wrdata,
	output trace_op_t                  lk_op,
	output logic [`PROF_FUNC_BITS-1:0] lk_func,
	output logic                       lk_inc
);
	localparam int ENTRIES = `PROF_UNKNOWN_FUNC;

	logic [31:0]                entry_pc [ENTRIES];
	logic [ENTRIES-1:0]         entry_vld;
	logic [`PROF_FUNC_BITS-1:0] wr_slot;
	logic                       wr_ok;
	logic [`PROF_FUNC_BITS-1:0] hit_func;

	assign wr_slot = mm_addr[`PROF_FUNC_BITS-1:0];
	assign wr_ok = tbl_wren && (wr_slot < `PROF_FUNC_BITS'(ENTRIES));

	// Scan from the top so the lowest matching slot is left
	always_comb begin
		hit_func = `PROF_FUNC_BITS'(`PROF_UNKNOWN_FUNC);
		for (int i = ENTRIES - 1; i >= 0; i--) begin
			if (entry_vld[i] && (entry_pc[i] == ev_pc))
				hit_func = `PROF_FUNC_BITS'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			entry_vld <= '0;
			lk_op     <= OP_NONE;
			lk_inc    <= 1'b0;
		end else begin
			if (wr_ok)
				entry_vld[wr_slot] <= 1'b1;
			lk_op  <= ev_op;
			lk_inc <= ev_inc;
		end
	end

	// Entry PCs and the matched number
	always_ff @(posedge clk) begin
		if (wr_ok)
			entry_pc[wr_slot] <= mm_wrdata;
		lk_func <= hit_func;
	end
endmodule

// ==== hw/prof_call_stack.sv ====
// Calls past the stack depth are dropped; an event charges the top frame after its push or pop
`timescale 1ns/1ps
`include "prof_params.svh"

module prof_call_stack import prof_event_pkg::*; (
	input  logic                         clk,
	input  logic                         reset,
	input  trace_op_t                    lk_op,
	input  logic [`PROF_FUNC_BITS-1:0]   lk_func,
	input  logic                         lk_inc,
	input  logic                         do_hier,
	output logic [`PROF_NUM_BANKS-1:0]   bank_add_en,
	output logic [`PROF_SLOT_BITS-1:0]   bank_add_slot,
	output logic [`PROF_COUNT_WIDTH-1:0] bank_add_amt,
	output logic                         exe_start,
	output logic                         exe_end
);
	localparam int IDX_BITS = $clog2(`PROF_STACK_DEPTH);
	localparam int SP_BITS = IDX_BITS + 1;

	logic [`PROF_FUNC_BITS-1:0]   frame_func [`PROF_STACK_DEPTH];
	logic [`PROF_COUNT_WIDTH-1:0] frame_tot [`PROF_STACK_DEPTH];
	logic [SP_BITS-1:0]           sp;
	logic                         done;
	logic [IDX_BITS-1:0]          top_idx;
	logic [IDX_BITS-1:0]          caller_idx;
	logic                         stack_empty;
	logic                         stack_full;
	logic                         last_frame;
	logic                         do_push;
	logic                         do_pop;
	logic                         chg_en;
	logic [`PROF_FUNC_BITS-1:0]   chg_func;
	logic [`PROF_COUNT_WIDTH-1:0] chg_amt;
	logic [`PROF_COUNT_WIDTH-1:0] inc_amt;

	assign inc_amt = `PROF_COUNT_WIDTH'(lk_inc);
	assign stack_empty = (sp == '0);
	assign stack_full = (sp == SP_BITS'(`PROF_STACK_DEPTH));
	assign last_frame = (sp == SP_BITS'(1));
	assign top_idx = IDX_BITS'(sp - SP_BITS'(1));
	assign caller_idx = IDX_BITS'(sp - SP_BITS'(2));

	// Nothing moves once main has returned
	assign do_push = !done && (lk_op == OP_CALL) && !stack_full;
	assign do_pop = !done && (lk_op == OP_RETN) && !stack_empty;

	// Pick who gets charged and by how much
	always_comb begin
		chg_en   = 1'b0;
		chg_func = frame_func[top_idx];
		chg_amt  = inc_amt;
		if (do_push) begin
			chg_en   = lk_inc;
			chg_func = lk_func;
		end else if (do_pop) begin
			chg_func = frame_func[caller_idx];
			// Popping main charges nobody
			if (!last_frame) begin
				chg_en = lk_inc || do_hier;
				// Callee total rides along with the return
				if (do_hier)
					chg_amt = frame_tot[top_idx] + inc_amt;
			end
		end else if (!done && !stack_empty)
			chg_en = lk_inc;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sp          <= '0;
			done        <= 1'b0;
			bank_add_en <= '0;
			exe_start   <= 1'b0;
			exe_end     <= 1'b0;
		end else begin
			// One-hot strobe on the bank of the charged function
			bank_add_en <= '0;
			if (chg_en)
				bank_add_en[chg_func[`PROF_BANK_BITS-1:0]] <= 1'b1;
			exe_start <= do_push && stack_empty;
			exe_end   <= do_pop && last_frame;
			if (do_push)
				sp <= sp + SP_BITS'(1);
			else if (do_pop) begin
				sp <= sp - SP_BITS'(1);
				if (last_frame)
					done <= 1'b1;
			end
		end
	end

	// Frames and charge payload
	always_ff @(posedge clk) begin
		bank_add_slot <= chg_func[`PROF_FUNC_BITS-1:`PROF_BANK_BITS];
		bank_add_amt  <= chg_amt;
		if (do_push) begin
			frame_func[sp[IDX_BITS-1:0]] <= lk_func;
			frame_tot[sp[IDX_BITS-1:0]]  <= inc_amt;
		end else if (do_pop) begin
			// Caller total stays inclusive for its own return
			if (!last_frame)
				frame_tot[caller_idx] <= frame_tot[caller_idx] + chg_amt;
		end else if (chg_en)
			frame_tot[top_idx] <= frame_tot[top_idx] + inc_amt;
	end
endmodule

// ==== hw/prof_counter_bank.sv ====
// Counters only clear at reset and wrap silently; rd_count is combinational from rd_slot
`timescale 1ns/1ps
`include "prof_params.svh"

module prof_counter_bank (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         add_en,
	input  logic [`PROF_SLOT_BITS-1:0]   add_slot,
	input  logic [`PROF_COUNT_WIDTH-1:0] add_amt,
	input  logic [`PROF_SLOT_BITS-1:0]   rd_slot,
	output logic [`PROF_COUNT_WIDTH-1:0] rd_count
);
	localparam int SLOTS = `PROF_NUM_FUNCS / `PROF_NUM_BANKS;

	logic [`PROF_COUNT_WIDTH-1:0] count [SLOTS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < SLOTS; i++)
				count[i] <= '0;
		end else if (add_en)
			count[add_slot] <= count[add_slot] + add_amt;
	end

	// Read port for the readout mux
	assign rd_count = count[rd_slot];
endmodule

// ==== hw/prof_readout.sv ====
// Read data appears one cycle after mm_addr; every address reads a counter by its low four bits
`timescale 1ns/1ps
`include "prof_params.svh"

module prof_readout (
	input  logic                                            clk,
	input  logic                                            reset,
	input  logic [`PROF_ADDR_BITS-1:0]                      mm_addr,
	input  logic [`PROF_NUM_BANKS-1:0][`PROF_COUNT_WIDTH-1:0] bank_count,
	output logic [`PROF_SLOT_BITS-1:0]                      rd_slot,
	output logic [`PROF_COUNT_WIDTH-1:0]                    mm_rddata
);
	// Slot within a bank from the high function bits
	assign rd_slot = mm_addr[`PROF_FUNC_BITS-1:`PROF_BANK_BITS];

	// Bank from the low bits, registered
	always_ff @(posedge clk) begin
		if (reset)
			mm_rddata <= '0;
		else
			mm_rddata <= bank_count[mm_addr[`PROF_BANK_BITS-1:0]];
	end
endmodule

// ==== hw/leap_profiler.sv ====
// Four cycles from trace to counter, no back-pressure; profiling runs once per reset
`timescale 1ns/1ps
`include "prof_params.svh"

module leap_profiler import prof_event_pkg::*; (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [31:0]                  pc_in,
	input  logic [31:0]                  instr_in,
	input  logic                         ins_valid,
	input  logic                         istall,
	input  logic                         dstall,
	output logic                         exe_start,
	output logic                         exe_end,
	input  logic [`PROF_ADDR_BITS-1:0]   mm_addr,
	input  logic                         mm_wren,
	input  logic [31:0]                  mm_wrdata,
	output logic [`PROF_COUNT_WIDTH-1:0] mm_rddata
);
	inc_sel_t                     inc_mask;
	logic                         do_hier;
	logic [31:0]                  init_pc;
	logic                         tbl_wren;
	logic [31:0]                  ev_pc;
	trace_op_t                    ev_op;
	logic                         ev_inc;
	trace_op_t                    lk_op;
	logic [`PROF_FUNC_BITS-1:0]   lk_func;
	logic                         lk_inc;
	logic [`PROF_NUM_BANKS-1:0]   bank_add_en;
	logic [`PROF_SLOT_BITS-1:0]   bank_add_slot;
	logic [`PROF_COUNT_WIDTH-1:0] bank_add_amt;
	logic [`PROF_SLOT_BITS-1:0]   rd_slot;
	logic [`PROF_NUM_BANKS-1:0][`PROF_COUNT_WIDTH-1:0] bank_count;

	prof_config_regs config_regs_inst (.clk, .reset, .mm_addr, .mm_wren, .mm_wrdata,
		.inc_mask, .do_hier, .init_pc, .tbl_wren);

	// Stage 1, start filter and decode
	prof_trace_front trace_front_inst (.clk, .reset, .pc_in, .instr_in, .ins_valid, .istall,
		.dstall, .inc_mask, .init_pc, .ev_pc, .ev_op, .ev_inc);

	// Stage 2, target to function number
	prof_func_lookup func_lookup_inst (.clk, .reset, .ev_pc, .ev_op, .ev_inc, .tbl_wren,
		.mm_addr, .mm_wrdata, .lk_op, .lk_func, .lk_inc);

	// Stage 3, stack and charge routing
	prof_call_stack call_stack_inst (.clk, .reset, .lk_op, .lk_func, .lk_inc, .do_hier,
		.bank_add_en, .bank_add_slot, .bank_add_amt, .exe_start, .exe_end);

	// Stage 4, one bank per low function bits value
	for (genvar b = 0; b < `PROF_NUM_BANKS; b++) begin : g_bank
		prof_counter_bank counter_bank_inst (.clk, .reset, .add_en(bank_add_en[b]),
			.add_slot(bank_add_slot), .add_amt(bank_add_amt), .rd_slot,
			.rd_count(bank_count[b]));
	end

	prof_readout readout_inst (.clk, .reset, .mm_addr, .bank_count, .rd_slot, .mm_rddata);
endmodule

// ==== tb/leap_profiler_properties.sv ====
// Strobe and pulse rules on the top level only; counter values are not checked here
`timescale 1ns/1ps
`include "prof_params.svh"

module leap_profiler_properties (
	input logic                       clk,
	input logic                       reset,
	input logic [`PROF_NUM_BANKS-1:0] bank_add_en,
	input logic                       exe_start,
	input logic                       exe_end
);
	// A charge goes to one bank at most
	strobe_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(bank_add_en))
		else $error("more than one bank_add_en strobe active in one cycle");

	// Start and end of execution are separate events
	pulses_apart: assert property (@(posedge clk) disable iff (reset) !(exe_start && exe_end))
		else $error("exe_start and exe_end active in the same cycle");

	// Held quiet once reset has been seen on an edge
	quiet_in_reset: assert property (@(posedge clk) (reset && $past(reset)) |->
		(!exe_start && !exe_end))
		else $error("exe_start or exe_end active during reset");
endmodule

// ==== tb/leap_profiler_tb.sv ====
// Directed traces use jal and jr $31 but no jalr, and stall cycles hold the previous pc
`timescale 1ns/1ps
`include "prof_params.svh"

module leap_profiler_tb import prof_event_pkg::*, prof_map_pkg::*; ();
	localparam int CLK_PERIOD = 20;
	// Seven reset-to-readout runs, each well under this many cycles
	localparam int RUNS = 7;
	localparam int RUN_CYCLES = 150;
	localparam logic [31:0] NOP = 32'd0;
	localparam logic [31:0] JR_RA = {6'd0, 5'd31, 15'd0, 6'd8};

	logic                         clk;
	logic                         reset;
	logic [31:0]                  pc_in;
	logic [31:0]                  instr_in;
	logic                         ins_valid;
	logic                         istall;
	logic                         dstall;
	logic                         exe_start;
	logic                         exe_end;
	logic [`PROF_ADDR_BITS-1:0]   mm_addr;
	logic                         mm_wren;
	logic [31:0]                  mm_wrdata;
	logic [`PROF_COUNT_WIDTH-1:0] mm_rddata;

	// Reference model state
	logic [31:0] lfsr;
	logic [31:0] tbl_pc [`PROF_UNKNOWN_FUNC];
	bit          tbl_vld [`PROF_UNKNOWN_FUNC];
	logic [31:0] exp_cnt [`PROF_NUM_FUNCS];
	int          stk_func [`PROF_STACK_DEPTH];
	logic [31:0] stk_tot [`PROF_STACK_DEPTH];
	int          msp;
	logic        m_started;
	logic        m_done;
	logic        m_hier;
	inc_sel_t    m_mask;
	logic [31:0] m_init_pc;
	logic [31:0] prev_pc;
	int          exp_starts;
	int          exp_ends;
	int          seen_starts;
	int          seen_ends;
	int          base_starts;
	int          base_ends;

	leap_profiler leap_profiler_inst (.*);

	bind leap_profiler leap_profiler_properties props_inst (.clk, .reset, .bank_add_en,
		.exe_start, .exe_end);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Run length bound
	initial begin
		#((RUNS * RUN_CYCLES + 200) * CLK_PERIOD);
		$display("STATUS: FAIL");
		$fatal(1, "Timeout: the tests did not finish in the expected time");
	end

	// Pulse counters sample away from the active edge
	always @(negedge clk) begin
		if (!reset) begin
			if (exe_start)
				seen_starts++;
			if (exe_end)
				seen_ends++;
		end
	end

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bit(output logic b);
		lfsr = lfsr_next(lfsr);
		b = lfsr[0];
	endtask

	function automatic logic [31:0] jal_to(input logic [31:0] target);
		return {6'd3, target[27:2]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at time %0t: %s expected %0d, got %0d", $time, name, expected,
				actual);
			$display("STATUS: FAIL");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Lowest table slot wins and no entry means the catch-all number
	function automatic int func_of(input logic [31:0] target);
		for (int i = 0; i < `PROF_UNKNOWN_FUNC; i++) begin
			if (tbl_vld[i] && tbl_pc[i] == target)
				return i;
		end
		return `PROF_UNKNOWN_FUNC;
	endfunction

	// New frame takes this cycle's increment
	// Pushes past the depth do not occur in these traces
	task automatic push_frame(input int f, input logic inc);
		if (msp == 0)
			exp_starts++;
		if (msp < `PROF_STACK_DEPTH) begin
			stk_func[msp] = f;
			stk_tot[msp] = 32'(inc);
			exp_cnt[f] += 32'(inc);
			msp++;
		end
	endtask

	// Charging rule per sampled cycle without the pipeline delay
	task automatic model_cycle(input logic [31:0] pc, input logic [31:0] instr,
		input logic valid, input logic ist, input logic dst);
		logic        inc;
		logic [31:0] amt;
		inc = (m_mask == INC_INSTR && valid && pc != prev_pc) || m_mask == INC_CYCLE
			|| (m_mask == INC_STALL && (ist || dst)) || (m_mask == INC_ISTALL && ist)
			|| (m_mask == INC_DSTALL && dst);
		prev_pc = pc;
		if (!m_started) begin
			if (pc == m_init_pc) begin
				m_started = 1'b1;
				push_frame(func_of(pc), inc);
			end
		end else if (!m_done) begin
			if (valid && instr[31:26] == 6'd3)
				push_frame(func_of({pc[31:28], instr[25:0], 2'b00}), inc);
			else if (valid && instr == JR_RA && msp == 1) begin
				// Main returns and nobody is left to charge
				msp = 0;
				m_done = 1'b1;
				exp_ends++;
			end else if (valid && instr == JR_RA) begin
				msp--;
				amt = m_hier ? stk_tot[msp] + 32'(inc) : 32'(inc);
				exp_cnt[stk_func[msp - 1]] += amt;
				stk_tot[msp - 1] += amt;
			end else if (msp > 0 && inc) begin
				exp_cnt[stk_func[msp - 1]] += 1;
				stk_tot[msp - 1] += 1;
			end
		end
	endtask

	task automatic drive_cycle(input logic [31:0] pc, input logic [31:0] instr,
		input logic valid, input logic ist, input logic dst);
		@(posedge clk);
		#2;
		pc_in = pc;
		instr_in = instr;
		ins_valid = valid;
		istall = ist;
		dstall = dst;
		model_cycle(pc, instr, valid, ist, dst);
	endtask

	// Zero to three stall cycles of one kind before the instruction
	task automatic exec(input logic [31:0] pc, input logic [31:0] instr);
		logic b0;
		logic b1;
		logic kind;
		take_bit(b0);
		take_bit(b1);
		take_bit(kind);
		repeat ({b1, b0}) drive_cycle(pc_in, NOP, 1'b0, !kind, kind);
		drive_cycle(pc, instr, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic idle(input int n);
		repeat (n) drive_cycle(pc_in, NOP, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk);
		#2;
		mm_addr = addr;
		mm_wren = 1'b1;
		mm_wrdata = data;
		@(posedge clk);
		#2;
		mm_wren = 1'b0;
	endtask

	task automatic table_entry(input int slot, input logic [31:0] pc);
		bus_write(8'(slot), pc);
		tbl_pc[slot] = pc;
		tbl_vld[slot] = 1'b1;
	endtask

	task automatic configure(input inc_sel_t mask, input logic hier, input logic [31:0] init);
		bus_write(8'h80 | 8'(CFG_INC_MASK), 32'(mask));
		bus_write(8'h80 | 8'(CFG_DO_HIER), 32'(hier));
		bus_write(8'h80 | 8'(CFG_INIT_PC), init);
		m_mask = mask;
		m_hier = hier;
		m_init_pc = init;
	endtask

	// Reset for three cycles and clear the model
	task automatic start_run();
		@(posedge clk);
		#2;
		reset = 1'b1;
		pc_in = '0;
		instr_in = NOP;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		msp = 0;
		m_started = 1'b0;
		m_done = 1'b0;
		m_hier = 1'b0;
		m_mask = '0;
		m_init_pc = '1;
		prev_pc = '0;
		exp_starts = 0;
		exp_ends = 0;
		base_starts = seen_starts;
		base_ends = seen_ends;
		for (int i = 0; i < `PROF_NUM_FUNCS; i++)
			exp_cnt[i] = '0;
		for (int i = 0; i < `PROF_UNKNOWN_FUNC; i++)
			tbl_vld[i] = 1'b0;
	endtask

	// Data for each address is checked while the next address is already presented
	task automatic read_counters();
		@(posedge clk);
		#2;
		mm_addr = '0;
		for (int f = 0; f < `PROF_NUM_FUNCS; f++) begin
			@(posedge clk);
			#2;
			mm_addr = 8'((f + 1) % `PROF_NUM_FUNCS);
			#1;
			check_value($sformatf("mm_rddata[func %0d]", f), mm_rddata, exp_cnt[f]);
		end
	endtask

	task automatic check_results();
		check_value("exe_start pulses", seen_starts - base_starts, exp_starts);
		check_value("exe_end pulses", seen_ends - base_ends, exp_ends);
		read_counters();
	endtask

	// Nothing counts before init_pc even across a jal and a return
	task automatic filter_before_start();
		start_run();
		table_entry(0, 32'h400);
		table_entry(1, 32'h1000);
		configure(INC_INSTR, 1'b0, 32'h400);
		exec(32'h100, NOP);
		exec(32'h104, jal_to(32'h1000));
		exec(32'h1000, NOP);
		exec(32'h1004, JR_RA);
		exec(32'h108, NOP);
		idle(8);
		check_results();
		exec(32'h400, NOP);
		exec(32'h404, jal_to(32'h1000));
		exec(32'h1000, NOP);
		exec(32'h1004, NOP);
		idle(8);
		check_results();
	endtask

	// Main calls A then B with flat charging under the given option
	task automatic count_flat_calls(input inc_sel_t mask);
		start_run();
		table_entry(0, 32'h400);
		table_entry(1, 32'h1000);
		table_entry(2, 32'h2000);
		configure(mask, 1'b0, 32'h400);
		exec(32'h400, NOP);
		exec(32'h404, jal_to(32'h1000));
		exec(32'h1000, NOP);
		exec(32'h1004, NOP);
		exec(32'h1008, JR_RA);
		exec(32'h408, jal_to(32'h2000));
		exec(32'h2000, NOP);
		exec(32'h2004, JR_RA);
		exec(32'h40c, NOP);
		exec(32'h410, JR_RA);
		idle(8);
		check_results();
	endtask

	// Nested A to B where B's total folds into A on return
	task automatic fold_nested_calls();
		start_run();
		table_entry(0, 32'h400);
		table_entry(1, 32'h1000);
		table_entry(2, 32'h2000);
		configure(INC_INSTR, 1'b1, 32'h400);
		exec(32'h400, NOP);
		exec(32'h404, jal_to(32'h1000));
		exec(32'h1000, NOP);
		exec(32'h1004, jal_to(32'h2000));
		exec(32'h2000, NOP);
		exec(32'h2004, NOP);
		exec(32'h2008, JR_RA);
		exec(32'h1008, NOP);
		exec(32'h100c, JR_RA);
		exec(32'h408, NOP);
		exec(32'h40c, JR_RA);
		idle(8);
		check_results();
	endtask

	// Unknown target lands on 15
	// Slot 7 repeats the pc of slot 5
	task automatic route_unknown_target();
		start_run();
		table_entry(0, 32'h400);
		table_entry(5, 32'h1500);
		table_entry(7, 32'h1500);
		table_entry(14, 32'h1e00);
		configure(INC_CYCLE, 1'b0, 32'h400);
		exec(32'h400, NOP);
		exec(32'h404, jal_to(32'h3000));
		exec(32'h3000, NOP);
		exec(32'h3004, JR_RA);
		exec(32'h408, jal_to(32'h1500));
		exec(32'h1500, NOP);
		exec(32'h1504, JR_RA);
		exec(32'h40c, jal_to(32'h1e00));
		exec(32'h1e00, JR_RA);
		exec(32'h410, JR_RA);
		idle(8);
		check_results();
	endtask

	initial begin
		reset = 1'b1;
		pc_in = '0;
		instr_in = NOP;
		ins_valid = 1'b0;
		istall = 1'b0;
		dstall = 1'b0;
		mm_addr = '0;
		mm_wren = 1'b0;
		mm_wrdata = '0;
		lfsr = 32'h96da;
		filter_before_start();
		count_flat_calls(INC_CYCLE);
		count_flat_calls(INC_ISTALL);
		count_flat_calls(INC_DSTALL);
		count_flat_calls(INC_STALL);
		fold_nested_calls();
		route_unknown_target();
		$display("STATUS: PASS");
		$finish;
	end
endmodule

// ==== sources.f ====
+incdir+include
hw/prof_event_pkg.sv
hw/prof_map_pkg.sv
hw/prof_config_regs.sv
hw/prof_trace_front.sv
hw/prof_func_lookup.sv
hw/prof_call_stack.sv
hw/prof_counter_bank.sv
hw/prof_readout.sv
hw/leap_profiler.sv
tb/leap_profiler_properties.sv
tb/leap_profiler_tb.sv

// ==== Makefile ====
# Verilator run of the profiler testbench, exit status carries pass or fail

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module leap_profiler_tb -o leap_profiler_sim
	./obj_dir/leap_profiler_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean
